// File: src.f
lx_pkg.sv
hazard_scoreboard.sv
long_issue.sv
int_divider.sv
mac_pipe.sv
reg_file.sv
long_exec_top.sv
tb_long_exec.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the long execution cluster testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_long_exec -f src.f -o sim_long_exec; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_long_exec > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
echo "simulation reported failure, see $LOG"
exit 1

// File: tb_long_exec.sv
// testbench for the long execution cluster with directed and random ops against an in-order model
`timescale 1ns/100ps
`default_nettype none

module tb_long_exec import lx_pkg::*; ();

    localparam int MAC_LATENCY = 3;   // accept edge to write edge
    localparam int DIV_LATENCY = 33;  // DIV_CYCLES + 1
    localparam int N_DIRECTED  = 13;
    localparam int N_RANDOM    = 300;
    localparam int WDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 40 + 2000;

    logic        clk;
    logic        rst_n;
    logic        in_valid_i;
    logic        in_ready_o;
    lx_op_e      in_op_i;
    logic [4:0]  in_rd_i;
    logic [4:0]  in_rs1_i;
    logic [4:0]  in_rs2_i;
    logic [4:0]  in_rs3_i;
    logic        ext_we_i;
    logic [4:0]  ext_waddr_i;
    logic [31:0] ext_wdata_i;
    logic [4:0]  ext_raddr_i;
    logic [31:0] ext_rdata_o;
    logic        lock_o;

    logic [31:0] mdl [32];               // architectural state in program order
    logic [31:0] rng_state = 32'hbd88_65b5;
    int          cyc = 0;                // rising edges since start
    int          max_done;               // last predicted commit edge
    int          errors;
    int          checks;
    int          lock_errs = 0;          // lock monitor tallies
    int          lock_checks = 0;

    long_exec_top DUT (
        .clk(clk), .rst_n(rst_n),
        .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_op_i(in_op_i),
        .in_rd_i(in_rd_i), .in_rs1_i(in_rs1_i), .in_rs2_i(in_rs2_i), .in_rs3_i(in_rs3_i),
        .ext_we_i(ext_we_i), .ext_waddr_i(ext_waddr_i), .ext_wdata_i(ext_wdata_i),
        .ext_raddr_i(ext_raddr_i), .ext_rdata_o(ext_rdata_o), .lock_o(lock_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    always @(posedge clk) cyc <= cyc + 1;

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // unsigned div and rem where x/0 gives all ones and rem = dividend
    function automatic logic [31:0] model_result(input lx_op_e op, input logic [31:0] a,
                                                 input logic [31:0] b, input logic [31:0] c);
        case (op)
            OP_DIV:  return (b == 32'd0) ? 32'hFFFF_FFFF : a / b;
            OP_REM:  return (b == 32'd0) ? a : a % b;
            default: return a * b + c;  // low word only
        endcase
    endfunction

    // lock must track the predicted pending set
    always @(negedge clk) begin
        if (rst_n) begin
            lock_checks++;
            if (lock_o !== (cyc < max_done)) begin
                lock_errs++;
                $display("Error @%0t: lock_o is %b, expected %b", $time, lock_o, cyc < max_done);
            end
        end
    end

    task automatic check_reg(input logic [4:0] addr, input logic [31:0] exp);
        ext_raddr_i = addr;
        #1;
        checks++;
        if (ext_rdata_o !== exp) begin
            errors++;
            $display("Error @%0t: x%0d reads %h, expected %h", $time, addr, ext_rdata_o, exp);
        end
    endtask

    task automatic ext_write(input logic [4:0] addr, input logic [31:0] data);
        if (lock_o) begin
            errors++;
            $display("External write to x%0d attempted while lock_o was high", addr);
        end
        ext_we_i    = 1'b1;
        ext_waddr_i = addr;
        ext_wdata_i = data;
        @(posedge clk);
        #2;
        ext_we_i = 1'b0;
        if (addr != 5'd0) mdl[addr] = data;
    endtask

    // offer one instruction, hold it until accepted, then retire it in the model
    task automatic send_instr(input lx_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [4:0] rs3, output int acc);
        int lat;
        lat         = (op == OP_MAC) ? MAC_LATENCY : DIV_LATENCY;
        in_valid_i  = 1'b1;
        in_op_i     = op;
        in_rd_i     = rd;
        in_rs1_i    = rs1;
        in_rs2_i    = rs2;
        in_rs3_i    = rs3;
        @(negedge clk);
        while (!in_ready_o) begin  // ready is settled mid cycle
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        acc        = cyc;
        in_valid_i = 1'b0;
        if (rd != 5'd0) begin
            mdl[rd] = model_result(op, mdl[rs1], mdl[rs2], mdl[rs3]);
            if (acc + lat > max_done) max_done = acc + lat;
        end
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (lock_o) @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    // three independent macs back to back with each result probed before, during and after its write
    task automatic mac_burst();
        logic [4:0]  dst   [3];
        logic [31:0] old_v [3];
        logic [31:0] new_v [3];
        for (int m = 0; m < 3; m++) begin
            dst[m]   = 5'(23 + m);
            old_v[m] = mdl[dst[m]];
            new_v[m] = model_result(OP_MAC, mdl[5'(m + 1)], mdl[4], mdl[2]);
        end
        for (int j = 0; j < 7; j++) begin
            in_valid_i = (j < 3);
            if (j < 3) begin
                in_op_i  = OP_MAC;
                in_rd_i  = dst[j];
                in_rs1_i = 5'(j + 1);
                in_rs2_i = 5'd4;
                in_rs3_i = 5'd2;
            end
            for (int m = 0; m < 3; m++) begin
                if (j == m + 2) check_reg(dst[m], old_v[m]);        // one cycle after accept
                if (j == m + 3 || j == m + 4) check_reg(dst[m], new_v[m]);
            end
            if (j < 3) begin
                @(negedge clk);
                checks++;
                if (!in_ready_o) begin
                    errors++;
                    $display("Error @%0t: MAC %0d not accepted back to back", $time, j);
                end
            end
            @(posedge clk);
            #2;
            if (j < 3) begin
                mdl[dst[j]] = new_v[j];
                max_done    = cyc + MAC_LATENCY;
            end
        end
        in_valid_i = 1'b0;
    endtask

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int          acc_div;
        int          acc_mac;
        int          gap;
        logic [31:0] tmp;
        lx_op_e      op;
        max_done    = 0;
        errors      = 0;
        checks      = 0;
        in_valid_i  = 1'b0;
        in_op_i     = OP_DIV;
        in_rd_i     = '0;
        in_rs1_i    = '0;
        in_rs2_i    = '0;
        in_rs3_i    = '0;
        ext_we_i    = 1'b0;
        ext_waddr_i = '0;
        ext_wdata_i = '0;
        ext_raddr_i = '0;
        mdl[0]      = 32'd0;
        rst_n       = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        checks++;
        if (!in_ready_o) begin
            errors++;
            $display("Error @%0t: in_ready_o low after reset", $time);
        end
        @(posedge clk);
        #2;
        for (int r = 1; r < 32; r++) ext_write(5'(r), next_rand());
        ext_write(5'd1, 32'd100);
        ext_write(5'd2, 32'd7);
        ext_write(5'd3, 32'hFFFF_FFF0);
        ext_write(5'd4, 32'd3);

        // directed div and rem with a zero divisor via x0 and an x0 target
        send_instr(OP_DIV, 5'd10, 5'd1, 5'd2, 5'd0, acc_div);
        send_instr(OP_REM, 5'd11, 5'd1, 5'd2, 5'd0, acc_div);
        send_instr(OP_DIV, 5'd12, 5'd3, 5'd0, 5'd0, acc_div);
        send_instr(OP_REM, 5'd13, 5'd3, 5'd0, 5'd0, acc_div);
        send_instr(OP_DIV, 5'd0, 5'd1, 5'd2, 5'd0, acc_div);
        send_instr(OP_REM, 5'd14, 5'd0, 5'd2, 5'd0, acc_div);
        wait_drain();
        check_reg(5'd10, 32'd14);
        check_reg(5'd11, 32'd2);
        check_reg(5'd12, 32'hFFFF_FFFF);
        check_reg(5'd13, 32'hFFFF_FFF0);
        check_reg(5'd14, 32'd0);
        check_reg(5'd0, 32'd0);

        mac_burst();
        wait_drain();

        // mac waits for the div quotient it reads
        send_instr(OP_DIV, 5'd20, 5'd1, 5'd2, 5'd0, acc_div);
        send_instr(OP_MAC, 5'd21, 5'd20, 5'd2, 5'd4, acc_mac);
        checks++;
        if (acc_mac != acc_div + DIV_LATENCY) begin
            errors++;
            $display("Error @%0t: RAW mac accepted at %0d, expected %0d", $time,
                     acc_mac, acc_div + DIV_LATENCY);
        end
        wait_drain();
        check_reg(5'd20, 32'd14);
        check_reg(5'd21, 32'd101);  // 14*7 + 3

        // later mac to the same rd must win
        send_instr(OP_DIV, 5'd22, 5'd1, 5'd4, 5'd0, acc_div);
        send_instr(OP_MAC, 5'd22, 5'd2, 5'd4, 5'd1, acc_mac);
        wait_drain();
        check_reg(5'd22, 32'd121);

        ext_write(5'd6, next_rand() & 32'hF);  // small divisor
        ext_write(5'd7, 32'd0);                // zero divisor
        for (int n = 0; n < N_RANDOM; n++) begin
            tmp = next_rand();
            case (tmp[31:16] % 16'd3)
                16'd0:   op = OP_DIV;
                16'd1:   op = OP_REM;
                default: op = OP_MAC;
            endcase
            send_instr(op, {2'b00, tmp[2:0]}, {2'b00, tmp[5:3]}, {2'b00, tmp[8:6]},
                       {2'b00, tmp[11:9]}, acc_div);
            gap = (tmp[15:14] == 2'd0) ? int'(tmp[13:12]) : 0;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
        end
        wait_drain();
        for (int r = 0; r < 32; r++) begin
            check_reg(5'(r), mdl[r]);
            @(posedge clk);
            #2;
        end

        errors = errors + lock_errs;
        checks = checks + lock_checks;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: long_exec_top.sv
// long execution cluster top: issue, scoreboard, divider, mac and register file
`timescale 1ns/100ps
`default_nettype none

module long_exec_top import lx_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  lx_op_e                in_op_i,
    input  logic [REG_ADDR_W-1:0] in_rd_i,
    input  logic [REG_ADDR_W-1:0] in_rs1_i,
    input  logic [REG_ADDR_W-1:0] in_rs2_i,
    input  logic [REG_ADDR_W-1:0] in_rs3_i,
    input  logic                  ext_we_i,
    input  logic [REG_ADDR_W-1:0] ext_waddr_i,
    input  logic [XLEN-1:0]       ext_wdata_i,
    input  logic [REG_ADDR_W-1:0] ext_raddr_i,
    output logic [XLEN-1:0]       ext_rdata_o,
    output logic                  lock_o
);

    // issue <-> scoreboard
    logic                  chk_valid;
    logic                  chk_fire;
    logic                  chk_we;
    logic                  stall;
    logic [CID_W-1:0]      alloc_id;
    logic                  rs1_re;
    logic                  rs2_re;
    logic                  rs3_re;
    // operand read
    logic [REG_ADDR_W-1:0] raddr1;
    logic [REG_ADDR_W-1:0] raddr2;
    logic [REG_ADDR_W-1:0] raddr3;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       rs3_data;
    // dispatch
    logic                  div_start;
    logic                  mac_start;
    logic                  div_idle;
    lx_op_e                op;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [XLEN-1:0]       c;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [CID_W-1:0]      cid;
    // completions
    logic                  cmt_int_valid;
    logic [CID_W-1:0]      cmt_int_id;
    logic                  wb_int_we;
    logic [REG_ADDR_W-1:0] wb_int_rd;
    logic [XLEN-1:0]       wb_int_data;
    logic                  cmt_mac_valid;
    logic [CID_W-1:0]      cmt_mac_id;
    logic                  wb_mac_we;
    logic [REG_ADDR_W-1:0] wb_mac_rd;
    logic [XLEN-1:0]       wb_mac_data;

    long_issue u_issue (
        .clk(clk), .rst_n(rst_n),
        .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_op_i(in_op_i),
        .in_rd_i(in_rd_i), .in_rs1_i(in_rs1_i), .in_rs2_i(in_rs2_i), .in_rs3_i(in_rs3_i),
        .chk_valid_o(chk_valid), .chk_fire_o(chk_fire), .chk_we_o(chk_we),
        .stall_i(stall), .alloc_id_i(alloc_id), .div_idle_i(div_idle),
        .rs1_re_o(rs1_re), .rs2_re_o(rs2_re), .rs3_re_o(rs3_re),
        .raddr1_o(raddr1), .raddr2_o(raddr2), .raddr3_o(raddr3),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .rs3_data_i(rs3_data),
        .div_start_o(div_start), .mac_start_o(mac_start), .op_o(op),
        .a_o(a), .b_o(b), .c_o(c), .rd_o(rd), .we_o(we), .cid_o(cid)
    );

    hazard_scoreboard u_sb (
        .clk(clk), .rst_n(rst_n),
        .chk_valid_i(chk_valid), .chk_fire_i(chk_fire),
        .rd_i(in_rd_i), .rs1_i(raddr1), .rs2_i(raddr2), .rs3_i(raddr3),
        .rd_we_i(chk_we), .rs1_re_i(rs1_re), .rs2_re_i(rs2_re), .rs3_re_i(rs3_re),
        .cmt_int_valid_i(cmt_int_valid), .cmt_int_id_i(cmt_int_id),
        .cmt_mac_valid_i(cmt_mac_valid), .cmt_mac_id_i(cmt_mac_id),
        .stall_o(stall), .alloc_id_o(alloc_id), .lock_o(lock_o)
    );

    int_divider u_div (
        .clk(clk), .rst_n(rst_n),
        .start_i(div_start), .op_i(op), .a_i(a), .b_i(b),
        .rd_i(rd), .we_i(we), .cid_i(cid), .idle_o(div_idle),
        .cmt_valid_o(cmt_int_valid), .cmt_id_o(cmt_int_id),
        .wb_we_o(wb_int_we), .wb_rd_o(wb_int_rd), .wb_data_o(wb_int_data)
    );

    mac_pipe u_mac (
        .clk(clk), .rst_n(rst_n),
        .start_i(mac_start), .a_i(a), .b_i(b), .c_i(c),
        .rd_i(rd), .we_i(we), .cid_i(cid),
        .cmt_valid_o(cmt_mac_valid), .cmt_id_o(cmt_mac_id),
        .wb_we_o(wb_mac_we), .wb_rd_o(wb_mac_rd), .wb_data_o(wb_mac_data)
    );

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n),
        .int_we_i(wb_int_we), .int_waddr_i(wb_int_rd), .int_wdata_i(wb_int_data),
        .mac_we_i(wb_mac_we), .mac_waddr_i(wb_mac_rd), .mac_wdata_i(wb_mac_data),
        .ext_we_i(ext_we_i), .ext_waddr_i(ext_waddr_i), .ext_wdata_i(ext_wdata_i),
        .raddr1_i(raddr1), .raddr2_i(raddr2), .raddr3_i(raddr3), .raddr4_i(ext_raddr_i),
        .lock_i(lock_o),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data), .rdata3_o(rs3_data),
        .rdata4_o(ext_rdata_o)
    );

endmodule

`default_nettype wire

// File: reg_file.sv
// register file: 32 x XLEN, three write ports, four reads with same-cycle bypass
`timescale 1ns/100ps
`default_nettype none

module reg_file import lx_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  int_we_i,
    input  logic [REG_ADDR_W-1:0] int_waddr_i,
    input  logic [XLEN-1:0]       int_wdata_i,
    input  logic                  mac_we_i,
    input  logic [REG_ADDR_W-1:0] mac_waddr_i,
    input  logic [XLEN-1:0]       mac_wdata_i,
    input  logic                  ext_we_i,
    input  logic [REG_ADDR_W-1:0] ext_waddr_i,
    input  logic [XLEN-1:0]       ext_wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    input  logic [REG_ADDR_W-1:0] raddr3_i,
    input  logic [REG_ADDR_W-1:0] raddr4_i,
    input  logic                  lock_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o,
    output logic [XLEN-1:0]       rdata3_o,
    output logic [XLEN-1:0]       rdata4_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // read with write-through, lets a commit clear a hazard in its own cycle
    function automatic logic [XLEN-1:0] rd_port(input logic [REG_ADDR_W-1:0] ra);
        if (ra == '0) return '0;  // x0 hardwired
        if (int_we_i && int_waddr_i == ra) return int_wdata_i;
        if (mac_we_i && mac_waddr_i == ra) return mac_wdata_i;
        if (ext_we_i && ext_waddr_i == ra) return ext_wdata_i;
        return regs[ra];
    endfunction

    always_comb begin
        rdata1_o = rd_port(raddr1_i);
        rdata2_o = rd_port(raddr2_i);
        rdata3_o = rd_port(raddr3_i);
        rdata4_o = rd_port(raddr4_i);
    end

    always_ff @(posedge clk) begin
        if (ext_we_i) regs[ext_waddr_i] <= ext_wdata_i;
        if (mac_we_i) regs[mac_waddr_i] <= mac_wdata_i;
        if (int_we_i) regs[int_waddr_i] <= int_wdata_i;
    end

    // core side stays out while long ops are pending
    a_ext_unlocked: assert property (@(posedge clk) disable iff (!rst_n)
        ext_we_i |-> !lock_i);
    // scoreboard WAW check keeps the two units apart
    a_wb_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        (int_we_i && mac_we_i) |-> (int_waddr_i != mac_waddr_i));

endmodule

`default_nettype wire

// File: mac_pipe.sv
// mac pipe: low word of a*b+c, multiply then add, fixed latency commit
`timescale 1ns/100ps
`default_nettype none

module mac_pipe import lx_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [XLEN-1:0]       a_i,
    input  logic [XLEN-1:0]       b_i,
    input  logic [XLEN-1:0]       c_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  we_i,
    input  logic [CID_W-1:0]      cid_i,
    output logic                  cmt_valid_o,
    output logic [CID_W-1:0]      cmt_id_o,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    // issue dispatch reg is stage one, so MAC_LAT-1 stages live here
    logic [MAC_LAT-2:0]    vld_q;
    logic [MAC_LAT-2:0]    we_q;
    logic [REG_ADDR_W-1:0] rd_q  [MAC_LAT-1];
    logic [CID_W-1:0]      cid_q [MAC_LAT-1];
    logic [XLEN-1:0]       prod_q;               // low word of a*b
    logic [XLEN-1:0]       addend_q;
    logic [XLEN-1:0]       sum_q [MAC_LAT-2];    // results after the add

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
            we_q  <= '0;
        end else begin
            vld_q <= {vld_q[MAC_LAT-3:0], start_i};
            we_q  <= {we_q[MAC_LAT-3:0], we_i};
        end
    end

    always_ff @(posedge clk) begin
        prod_q   <= a_i * b_i;
        addend_q <= c_i;
        rd_q[0]  <= rd_i;
        cid_q[0] <= cid_i;
        sum_q[0] <= prod_q + addend_q;  // wraps to XLEN
        for (int k = 1; k < MAC_LAT - 1; k++) begin
            rd_q[k]  <= rd_q[k-1];
            cid_q[k] <= cid_q[k-1];
        end
        for (int k = 1; k < MAC_LAT - 2; k++) begin
            sum_q[k] <= sum_q[k-1];
        end
    end

    assign cmt_valid_o = vld_q[MAC_LAT-2] && we_q[MAC_LAT-2];  // x0 target, no commit
    assign cmt_id_o    = cid_q[MAC_LAT-2];
    assign wb_we_o     = cmt_valid_o;
    assign wb_rd_o     = rd_q[MAC_LAT-2];
    assign wb_data_o   = sum_q[MAC_LAT-3];

endmodule

`default_nettype wire

// File: int_divider.sv
// integer divider: restoring unsigned div/rem, one bit per cycle, single commit pulse
`timescale 1ns/100ps
`default_nettype none

module int_divider import lx_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  lx_op_e                op_i,
    input  logic [XLEN-1:0]       a_i,      // dividend
    input  logic [XLEN-1:0]       b_i,      // divisor
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  we_i,
    input  logic [CID_W-1:0]      cid_i,
    output logic                  idle_o,
    output logic                  cmt_valid_o,
    output logic [CID_W-1:0]      cmt_id_o,
    output logic                  wb_we_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    typedef logic [$clog2(DIV_CYCLES)-1:0] cnt_t;

    div_state_e            state_q;
    cnt_t                  cnt_q;   // iterations done
    logic [XLEN-1:0]       rem_q;   // partial remainder
    logic [XLEN-1:0]       quo_q;   // dividend shifts out, quotient shifts in
    logic [XLEN-1:0]       dvs_q;
    lx_op_e                op_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic                  we_q;
    logic [CID_W-1:0]      cid_q;

    // one restoring step, returns {rem, quo}
    function automatic logic [2*XLEN-1:0] div_step(input logic [XLEN-1:0] rem,
                                                   input logic [XLEN-1:0] quo,
                                                   input logic [XLEN-1:0] dvs);
        logic [XLEN:0] trial;
        trial = {rem, quo[XLEN-1]} - {1'b0, dvs};
        if (trial[XLEN]) begin
            return {rem[XLEN-2:0], quo, 1'b0};          // borrow, keep shifted rem
        end
        return {trial[XLEN-1:0], quo[XLEN-2:0], 1'b1};
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_BUSY: begin
                    cnt_q <= cnt_q + cnt_t'(1);
                    if (cnt_q == cnt_t'(DIV_CYCLES - 1)) state_q <= DIV_DONE;
                end
                default: begin  // idle, or done and retiring
                    state_q <= start_i ? DIV_BUSY : DIV_IDLE;
                    cnt_q   <= cnt_t'(1);  // first step taken at start
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q != DIV_BUSY && start_i) begin
            {rem_q, quo_q} <= div_step('0, a_i, b_i);
            dvs_q <= b_i;
            op_q  <= op_i;
            rd_q  <= rd_i;
            we_q  <= we_i;
            cid_q <= cid_i;
        end else if (state_q == DIV_BUSY) begin
            {rem_q, quo_q} <= div_step(rem_q, quo_q, dvs_q);
        end
    end

    // divide by zero falls out of the steps: quo all ones, rem = dividend
    assign idle_o      = (state_q != DIV_BUSY);  // free again during commit
    assign cmt_valid_o = (state_q == DIV_DONE) && we_q;
    assign cmt_id_o    = cid_q;
    assign wb_we_o     = cmt_valid_o;
    assign wb_rd_o     = rd_q;
    assign wb_data_o   = (op_q == OP_REM) ? rem_q : quo_q;

endmodule

`default_nettype wire

// File: long_issue.sv
// long issue: valid/ready input, operand read and one-cycle dispatch to div or mac
`timescale 1ns/100ps
`default_nettype none

module long_issue import lx_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  lx_op_e                in_op_i,
    input  logic [REG_ADDR_W-1:0] in_rd_i,
    input  logic [REG_ADDR_W-1:0] in_rs1_i,
    input  logic [REG_ADDR_W-1:0] in_rs2_i,
    input  logic [REG_ADDR_W-1:0] in_rs3_i,
    output logic                  chk_valid_o,
    output logic                  chk_fire_o,
    output logic                  chk_we_o,     // rd is not x0
    input  logic                  stall_i,
    input  logic [CID_W-1:0]      alloc_id_i,
    input  logic                  div_idle_i,
    output logic                  rs1_re_o,
    output logic                  rs2_re_o,
    output logic                  rs3_re_o,
    output logic [REG_ADDR_W-1:0] raddr1_o,
    output logic [REG_ADDR_W-1:0] raddr2_o,
    output logic [REG_ADDR_W-1:0] raddr3_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic [XLEN-1:0]       rs3_data_i,
    output logic                  div_start_o,
    output logic                  mac_start_o,
    output lx_op_e                op_o,
    output logic [XLEN-1:0]       a_o,
    output logic [XLEN-1:0]       b_o,
    output logic [XLEN-1:0]       c_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic                  we_o,
    output logic [CID_W-1:0]      cid_o
);

    logic is_mac;
    logic is_div;   // div or rem
    logic unit_ok;  // target unit can take it
    logic fire;

    assign is_mac = (in_op_i == OP_MAC);
    assign is_div = (in_op_i == OP_DIV) || (in_op_i == OP_REM);

    assign rs1_re_o = is_mac || is_div;
    assign rs2_re_o = is_mac || is_div;
    assign rs3_re_o = is_mac;  // addend only for mac
    assign raddr1_o = in_rs1_i;
    assign raddr2_o = in_rs2_i;
    assign raddr3_o = in_rs3_i;

    // divider is single-issue, a start still sitting in dispatch counts as busy
    assign unit_ok    = is_mac || (is_div && div_idle_i && !div_start_o);
    assign in_ready_o = !stall_i && unit_ok;
    assign fire       = in_valid_i && in_ready_o;

    assign chk_valid_o = in_valid_i;
    assign chk_fire_o  = fire;
    assign chk_we_o    = (in_rd_i != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_start_o <= 1'b0;
            mac_start_o <= 1'b0;
        end else begin
            div_start_o <= fire && is_div;
            mac_start_o <= fire && is_mac;
        end
    end

    // dispatch payload, operands as read in the accept cycle
    always_ff @(posedge clk) begin
        if (fire) begin
            op_o  <= in_op_i;
            a_o   <= rs1_data_i;
            b_o   <= rs2_data_i;
            c_o   <= rs3_data_i;
            rd_o  <= in_rd_i;
            we_o  <= chk_we_o;
            cid_o <= alloc_id_i;
        end
    end

    a_div_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        div_start_o |-> div_idle_i);

endmodule

`default_nettype wire

// File: hazard_scoreboard.sv
// hazard scoreboard: tracks in-flight long ops, flags RAW/WAW, hands out commit ids
`timescale 1ns/100ps
`default_nettype none

module hazard_scoreboard import lx_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  chk_valid_i,   // instruction on offer
    input  logic                  chk_fire_i,    // instruction accepted this edge
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic [REG_ADDR_W-1:0] rs1_i,
    input  logic [REG_ADDR_W-1:0] rs2_i,
    input  logic [REG_ADDR_W-1:0] rs3_i,
    input  logic                  rd_we_i,
    input  logic                  rs1_re_i,
    input  logic                  rs2_re_i,
    input  logic                  rs3_re_i,
    input  logic                  cmt_int_valid_i,
    input  logic [CID_W-1:0]      cmt_int_id_i,
    input  logic                  cmt_mac_valid_i,
    input  logic [CID_W-1:0]      cmt_mac_id_i,
    output logic                  stall_o,
    output logic [CID_W-1:0]      alloc_id_o,
    output logic                  lock_o
);

    logic [SB_DEPTH-1:0]   ent_vld;            // entry holds a pending write
    logic [REG_ADDR_W-1:0] ent_rd [SB_DEPTH];  // its destination
    logic [SB_DEPTH-1:0]   cmt_hit;            // entry retiring this cycle
    logic [SB_DEPTH-1:0]   raw_vec;
    logic [SB_DEPTH-1:0]   waw_vec;
    logic                  hazard;
    logic [CID_W-1:0]      free_id;

    // parallel compare against every entry, retiring entries already count as done
    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            cmt_hit[i] = (cmt_int_valid_i && cmt_int_id_i == CID_W'(i)) ||
                         (cmt_mac_valid_i && cmt_mac_id_i == CID_W'(i));
            raw_vec[i] = ent_vld[i] && !cmt_hit[i] &&
                         ((rs1_re_i && rs1_i == ent_rd[i]) ||
                          (rs2_re_i && rs2_i == ent_rd[i]) ||
                          (rs3_re_i && rs3_i == ent_rd[i]));
            waw_vec[i] = ent_vld[i] && !cmt_hit[i] && rd_we_i && rd_i == ent_rd[i];
        end
    end

    // lowest free slot wins
    always_comb begin
        free_id = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            if (!ent_vld[i]) free_id = CID_W'(i);
        end
    end

    assign hazard     = chk_valid_i && (|raw_vec || |waw_vec);
    assign stall_o    = hazard || (&ent_vld);  // full table also holds issue
    assign alloc_id_o = free_id;
    assign lock_o     = |ent_vld;              // anything still in flight

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_vld <= '0;
        end else begin
            if (cmt_int_valid_i) ent_vld[cmt_int_id_i] <= 1'b0;
            if (cmt_mac_valid_i) ent_vld[cmt_mac_id_i] <= 1'b0;
            if (chk_fire_i && rd_we_i) ent_vld[free_id] <= 1'b1;  // x0 writes need no entry
        end
    end

    always_ff @(posedge clk) begin
        if (chk_fire_i && rd_we_i) ent_rd[free_id] <= rd_i;
    end

    // units only ever retire ids handed out here
    a_int_cmt_live: assert property (@(posedge clk) disable iff (!rst_n)
        cmt_int_valid_i |-> ent_vld[cmt_int_id_i]);
    a_mac_cmt_live: assert property (@(posedge clk) disable iff (!rst_n)
        cmt_mac_valid_i |-> ent_vld[cmt_mac_id_i]);
    // issue must respect the stall
    a_no_fire_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        chk_fire_i |-> !stall_o);

endmodule

`default_nettype wire

// File: lx_pkg.sv
// long-latency execution cluster: shared widths, depths, latencies and encodings
`default_nettype none

package lx_pkg;

    localparam int XLEN       = 32;  // datapath width
    localparam int REG_ADDR_W = 5;   // x0..x31
    localparam int SB_DEPTH   = 8;   // scoreboard entries
    localparam int CID_W      = 3;   // commit id, indexes the scoreboard
    localparam int MAC_LAT    = 3;   // dispatch reg plus two mac stages
    localparam int DIV_CYCLES = 32;  // one quotient bit per cycle

    // long opcodes
    typedef enum logic [1:0] {
        OP_DIV = 2'd0,  // unsigned quotient
        OP_REM = 2'd1,  // unsigned remainder
        OP_MAC = 2'd2   // rs1*rs2 + rs3
    } lx_op_e;

    // divider fsm
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_BUSY = 2'd1,
        DIV_DONE = 2'd2  // commit cycle
    } div_state_e;

endpackage

`default_nettype wire
